//--- ooo_defines.svh
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// datapath width.
`define XLEN      32

// register spaces.
`define ARCH_REGS 32
`define PHYS_REGS 64
`define PREG_W    6

// window sizes.
`define ROB_DEPTH 16
`define ROB_W     4
`define IQ_DEPTH  8

// execution lanes.
`define NUM_ALU   3

`endif

//--- ooo_pkg.sv
`default_nettype none
`include "ooo_defines.svh"

package ooo_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_NOP
    } alu_op_t;

    // decoded instruction, still on architectural registers.
    typedef struct packed {
        alu_op_t          op;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic             has_imm;
        logic [`XLEN-1:0] imm;
        logic             writes_rd;
    } uop_t;

    typedef struct packed {
        uop_t              uop;
        logic [`PREG_W-1:0] psrc1;
        logic [`PREG_W-1:0] psrc2;
        logic [`PREG_W-1:0] pdst;
        logic [`ROB_W-1:0]  rob_idx;
    } renamed_uop_t;

    // one alu lane; b already holds the immediate for op-imm forms.
    typedef struct packed {
        logic               valid;
        alu_op_t            op;
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic [`PREG_W-1:0] pdst;
        logic [`ROB_W-1:0]  rob_idx;
        logic               writes_rd;
    } issue_pkt_t;

    typedef struct packed {
        logic               valid;
        logic [`PREG_W-1:0] pdst;
        logic [`ROB_W-1:0]  rob_idx;
        logic               writes_rd;
        logic [`XLEN-1:0]   value;
    } complete_t;

    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic [`XLEN-1:0] value;
    } retire_t;

endpackage

`default_nettype wire

//--- insn_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module insn_decoder (
    input  wire [`XLEN-1:0] insn,
    output ooo_pkg::uop_t   uop
);
    import ooo_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_op;
    logic       is_imm;
    logic       f7_zero;
    logic       f7_alt;
    logic       legal;
    logic       writes;
    alu_op_t    op;

    assign opcode  = insn[6:0];
    assign funct3  = insn[14:12];
    assign funct7  = insn[31:25];
    assign is_op   = (opcode == OPC_OP);
    assign is_imm  = (opcode == OPC_OP_IMM);
    assign f7_zero = (funct7 == 7'h00);
    assign f7_alt  = (funct7 == 7'h20);

    always_comb begin
        // non-shift immediates keep imm bits in funct7.
        legal = is_imm || f7_zero;
        case (funct3)
            3'b000: begin
                op    = (is_op && f7_alt) ? ALU_SUB : ALU_ADD;
                legal = is_imm || f7_zero || f7_alt;
            end
            3'b001: begin
                op    = ALU_SLL;
                legal = f7_zero;
            end
            3'b010: op = ALU_SLT;
            3'b011: op = ALU_SLTU;
            3'b100: op = ALU_XOR;
            3'b101: begin
                op    = f7_alt ? ALU_SRA : ALU_SRL;
                legal = f7_zero || f7_alt;
            end
            3'b110: op = ALU_OR;
            default: op = ALU_AND;
        endcase
    end

    // rd 0 and unknown opcodes turn into a nop on p0 sources.
    assign writes = (is_op || is_imm) && legal && (insn[11:7] != 5'd0);

    always_comb begin
        uop.op        = writes ? op : ALU_NOP;
        uop.rs1       = writes ? insn[19:15] : 5'd0;
        uop.rs2       = (writes && is_op) ? insn[24:20] : 5'd0;
        uop.rd        = insn[11:7];
        uop.has_imm   = is_imm;
        uop.writes_rd = writes;
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
            uop.imm = {{(`XLEN-5){1'b0}}, insn[24:20]};
        end else begin
            uop.imm = {{(`XLEN-12){insn[31]}}, insn[31:20]};
        end
    end

endmodule

`default_nettype wire

//--- rename_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module rename_unit (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire ooo_pkg::uop_t    uop,
    input  wire                   dispatch,
    input  wire [`ROB_W-1:0]      rob_tail,
    input  wire                   free_valid,
    input  wire [`PREG_W-1:0]     free_tag,
    output ooo_pkg::renamed_uop_t ren,
    output logic [`PREG_W-1:0]    old_pdst,
    output logic                  stall,
    output logic                  alloc_valid,
    output logic [`PREG_W-1:0]    alloc_tag
);
    localparam int FL_DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int FL_W     = $clog2(FL_DEPTH);
    localparam int CNT_W    = FL_W + 1;

    logic [`PREG_W-1:0] map_table [`ARCH_REGS];
    logic [`PREG_W-1:0] free_list [FL_DEPTH];
    logic [FL_W-1:0]    fl_head;
    logic [FL_W-1:0]    fl_tail;
    logic [CNT_W-1:0]   fl_count;
    logic               pop;

    // only writers need a fresh tag.
    assign stall = uop.writes_rd && (fl_count == '0);
    assign pop   = dispatch && uop.writes_rd;

    always_comb begin
        ren.uop     = uop;
        ren.psrc1   = map_table[uop.rs1];
        ren.psrc2   = map_table[uop.rs2];
        ren.pdst    = uop.writes_rd ? free_list[fl_head] : '0;
        ren.rob_idx = rob_tail;
    end

    assign old_pdst    = map_table[uop.rd];
    assign alloc_valid = pop;
    assign alloc_tag   = ren.pdst;

    // identity map out of reset.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_table[i] <= `PREG_W'(i);
            end
        end else if (pop) begin
            map_table[uop.rd] <= free_list[fl_head];
        end
    end

    // ring of free tags, full at reset with p32 upward.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                free_list[i] <= `PREG_W'(`ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= CNT_W'(FL_DEPTH);
        end else begin
            if (free_valid) begin
                free_list[fl_tail] <= free_tag;
                fl_tail            <= fl_tail + 1'b1;
            end
            if (pop) begin
                fl_head <= fl_head + 1'b1;
            end
            fl_count <= fl_count + CNT_W'(free_valid) - CNT_W'(pop);
        end
    end

endmodule

`default_nettype wire

//--- phys_regfile.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module phys_regfile (
    input  wire                                clk,
    input  wire                                rstn,
    input  wire [2*`NUM_ALU-1:0][`PREG_W-1:0]  rd_tag,
    input  wire                                alloc_valid,
    input  wire [`PREG_W-1:0]                  alloc_tag,
    input  wire ooo_pkg::complete_t [`NUM_ALU-1:0] complete,
    output logic [2*`NUM_ALU-1:0][`XLEN-1:0]   rd_data,
    output logic [`PHYS_REGS-1:0]              ready_bits
);
    logic [`XLEN-1:0] regs [`PHYS_REGS];

    // two operand ports per lane.
    always_comb begin
        for (int i = 0; i < 2*`NUM_ALU; i++) begin
            rd_data[i] = regs[rd_tag[i]];
        end
    end

    // cleared at reset so every x_i starts out as zero.
    // p0 is never written.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int j = 0; j < `NUM_ALU; j++) begin
                if (complete[j].valid && complete[j].writes_rd && complete[j].pdst != '0) begin
                    regs[complete[j].pdst] <= complete[j].value;
                end
            end
        end
    end

    // a new pdst waits for its producer.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ready_bits <= '1;
        end else begin
            if (alloc_valid && alloc_tag != '0) begin
                ready_bits[alloc_tag] <= 1'b0;
            end
            for (int j = 0; j < `NUM_ALU; j++) begin
                if (complete[j].valid && complete[j].writes_rd) begin
                    ready_bits[complete[j].pdst] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- issue_queue.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module issue_queue (
    input  wire                                clk,
    input  wire                                rstn,
    input  wire ooo_pkg::renamed_uop_t         ren,
    input  wire                                dispatch,
    input  wire [`PHYS_REGS-1:0]               ready_bits,
    input  wire [2*`NUM_ALU-1:0][`XLEN-1:0]    rd_data,
    input  wire ooo_pkg::complete_t [`NUM_ALU-1:0] complete,
    output logic                               stall,
    output logic [2*`NUM_ALU-1:0][`PREG_W-1:0] rd_tag,
    output ooo_pkg::issue_pkt_t [`NUM_ALU-1:0] issue
);
    import ooo_pkg::*;

    localparam int IQ_W = $clog2(`IQ_DEPTH);

    // slots stay compacted, slot 0 holds the oldest entry.
    renamed_uop_t         slot [`IQ_DEPTH];
    renamed_uop_t         nxt_slot [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0] slot_valid;
    logic [`IQ_DEPTH-1:0] rdy1;
    logic [`IQ_DEPTH-1:0] rdy2;
    logic [`IQ_DEPTH-1:0] nxt_valid;
    logic [`IQ_DEPTH-1:0] nxt_rdy1;
    logic [`IQ_DEPTH-1:0] nxt_rdy2;
    logic [`IQ_DEPTH-1:0] grant;
    logic [IQ_W-1:0]      sel [`NUM_ALU];
    logic [`NUM_ALU-1:0]  sel_valid;

    // ready in the file already, or being written this cycle.
    function automatic logic src_ready(input logic [`PREG_W-1:0] tag);
        logic hit;
        hit = ready_bits[tag];
        for (int j = 0; j < `NUM_ALU; j++) begin
            if (complete[j].valid && complete[j].writes_rd && complete[j].pdst == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign stall = &slot_valid;

    // oldest ready entries win, at most one per lane.
    always_comb begin
        int n;
        n         = 0;
        grant     = '0;
        sel_valid = '0;
        for (int k = 0; k < `NUM_ALU; k++) begin
            sel[k] = '0;
        end
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (slot_valid[i] && rdy1[i] && rdy2[i] && n < `NUM_ALU) begin
                grant[i]     = 1'b1;
                sel[n]       = IQ_W'(i);
                sel_valid[n] = 1'b1;
                n++;
            end
        end
    end

    always_comb begin
        for (int k = 0; k < `NUM_ALU; k++) begin
            rd_tag[2*k]        = sel_valid[k] ? slot[sel[k]].psrc1 : '0;
            rd_tag[2*k+1]      = sel_valid[k] ? slot[sel[k]].psrc2 : '0;
            issue[k].valid     = sel_valid[k];
            issue[k].op        = slot[sel[k]].uop.op;
            issue[k].a         = rd_data[2*k];
            issue[k].b         = slot[sel[k]].uop.has_imm ? slot[sel[k]].uop.imm
                                                          : rd_data[2*k+1];
            issue[k].pdst      = slot[sel[k]].pdst;
            issue[k].rob_idx   = slot[sel[k]].rob_idx;
            issue[k].writes_rd = slot[sel[k]].uop.writes_rd;
        end
    end

    // survivors shift down, the new entry lands behind them.
    always_comb begin
        int k;
        k         = 0;
        nxt_valid = '0;
        nxt_rdy1  = '0;
        nxt_rdy2  = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            nxt_slot[i] = slot[i];
        end
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (slot_valid[i] && !grant[i]) begin
                nxt_slot[k]  = slot[i];
                nxt_valid[k] = 1'b1;
                nxt_rdy1[k]  = rdy1[i] | src_ready(slot[i].psrc1);
                nxt_rdy2[k]  = rdy2[i] | src_ready(slot[i].psrc2);
                k++;
            end
        end
        if (dispatch && k < `IQ_DEPTH) begin
            nxt_slot[k]  = ren;
            nxt_valid[k] = 1'b1;
            nxt_rdy1[k]  = src_ready(ren.psrc1);
            nxt_rdy2[k]  = src_ready(ren.psrc2);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            slot_valid <= '0;
            rdy1       <= '0;
            rdy2       <= '0;
        end else begin
            slot_valid <= nxt_valid;
            rdy1       <= nxt_rdy1;
            rdy2       <= nxt_rdy2;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            slot[i] <= nxt_slot[i];
        end
    end

endmodule

`default_nettype wire

//--- alu_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module alu_unit (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire ooo_pkg::issue_pkt_t issue,
    output ooo_pkg::complete_t   result
);
    import ooo_pkg::*;

    logic [`XLEN-1:0]   value;
    logic [4:0]         shamt;
    logic               valid_q;
    logic [`PREG_W-1:0] pdst_q;
    logic [`ROB_W-1:0]  rob_idx_q;
    logic               writes_q;
    logic [`XLEN-1:0]   value_q;

    assign shamt = issue.b[4:0];

    always_comb begin
        case (issue.op)
            ALU_ADD:  value = issue.a + issue.b;
            ALU_SUB:  value = issue.a - issue.b;
            ALU_AND:  value = issue.a & issue.b;
            ALU_OR:   value = issue.a | issue.b;
            ALU_XOR:  value = issue.a ^ issue.b;
            ALU_SLL:  value = issue.a << shamt;
            ALU_SRL:  value = issue.a >> shamt;
            ALU_SRA:  value = $unsigned($signed(issue.a) >>> shamt);
            ALU_SLT:  value = `XLEN'($signed(issue.a) < $signed(issue.b));
            ALU_SLTU: value = `XLEN'(issue.a < issue.b);
            default:  value = '0;
        endcase
    end

    // one-cycle lane, an idle cycle leaves valid low.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        pdst_q    <= issue.pdst;
        rob_idx_q <= issue.rob_idx;
        writes_q  <= issue.writes_rd;
        value_q   <= value;
    end

    always_comb begin
        result.valid     = valid_q;
        result.pdst      = pdst_q;
        result.rob_idx   = rob_idx_q;
        result.writes_rd = writes_q;
        result.value     = value_q;
    end

endmodule

`default_nettype wire

//--- reorder_buffer.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module reorder_buffer (
    input  wire                                clk,
    input  wire                                rstn,
    input  wire ooo_pkg::renamed_uop_t         ren,
    input  wire [`PREG_W-1:0]                  old_pdst,
    input  wire                                dispatch,
    input  wire ooo_pkg::complete_t [`NUM_ALU-1:0] complete,
    output logic                               stall,
    output logic [`ROB_W-1:0]                  rob_tail,
    output ooo_pkg::retire_t                   retire,
    output logic                               free_valid,
    output logic [`PREG_W-1:0]                 free_tag
);
    localparam int CNT_W = `ROB_W + 1;

    logic [`ROB_DEPTH-1:0] done;
    logic [`ROB_DEPTH-1:0] writes;
    logic [4:0]            rd_arch [`ROB_DEPTH];
    logic [`PREG_W-1:0]    old_tag [`ROB_DEPTH];
    logic [`XLEN-1:0]      value [`ROB_DEPTH];
    logic [`ROB_W-1:0]     head;
    logic [CNT_W-1:0]      count;
    logic                  retire_now;

    assign stall      = (count == CNT_W'(`ROB_DEPTH));
    assign retire_now = (count != '0) && done[head];

    // the previous mapping of rd goes back once the writer retires.
    assign free_valid = retire_now && writes[head];
    assign free_tag   = old_tag[head];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head     <= '0;
            rob_tail <= '0;
            count    <= '0;
            done     <= '0;
        end else begin
            for (int j = 0; j < `NUM_ALU; j++) begin
                if (complete[j].valid) begin
                    done[complete[j].rob_idx] <= 1'b1;
                end
            end
            if (dispatch) begin
                done[rob_tail] <= 1'b0;
                rob_tail       <= rob_tail + 1'b1;
            end
            if (retire_now) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(dispatch) - CNT_W'(retire_now);
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            rd_arch[rob_tail] <= ren.uop.rd;
            old_tag[rob_tail] <= old_pdst;
            writes[rob_tail]  <= ren.uop.writes_rd;
        end
        for (int j = 0; j < `NUM_ALU; j++) begin
            if (complete[j].valid) begin
                value[complete[j].rob_idx] <= complete[j].value;
            end
        end
    end

    // non-writers report rd 0 and value 0.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            retire <= '0;
        end else begin
            retire.valid <= retire_now;
            retire.rd    <= (retire_now && writes[head]) ? rd_arch[head] : '0;
            retire.value <= (retire_now && writes[head]) ? value[head] : '0;
        end
    end

endmodule

`default_nettype wire

//--- ooo_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module ooo_core (
    input  wire              clk,
    input  wire              rstn,
    input  wire              insn_valid,
    input  wire [`XLEN-1:0]  insn,
    output logic             stall,
    output ooo_pkg::retire_t retire
);
    import ooo_pkg::*;

    uop_t                              uop;
    renamed_uop_t                      ren;
    issue_pkt_t [`NUM_ALU-1:0]         issue;
    complete_t [`NUM_ALU-1:0]          complete;
    logic                              dispatch;
    logic                              rn_stall;
    logic                              iq_stall;
    logic                              rob_stall;
    logic                              alloc_valid;
    logic                              free_valid;
    logic [`PREG_W-1:0]                old_pdst;
    logic [`PREG_W-1:0]                alloc_tag;
    logic [`PREG_W-1:0]                free_tag;
    logic [`ROB_W-1:0]                 rob_tail;
    logic [2*`NUM_ALU-1:0][`PREG_W-1:0] rd_tag;
    logic [2*`NUM_ALU-1:0][`XLEN-1:0]  rd_data;
    logic [`PHYS_REGS-1:0]             ready_bits;

    // any full structure holds the instruction at the input.
    assign stall    = rn_stall | iq_stall | rob_stall;
    assign dispatch = insn_valid & ~stall;

    insn_decoder u_dec (.insn(insn), .uop(uop));

    rename_unit u_ren (
        .clk(clk), .rstn(rstn), .uop(uop), .dispatch(dispatch), .rob_tail(rob_tail),
        .free_valid(free_valid), .free_tag(free_tag), .ren(ren), .old_pdst(old_pdst),
        .stall(rn_stall), .alloc_valid(alloc_valid), .alloc_tag(alloc_tag)
    );

    phys_regfile u_prf (
        .clk(clk), .rstn(rstn), .rd_tag(rd_tag), .alloc_valid(alloc_valid),
        .alloc_tag(alloc_tag), .complete(complete), .rd_data(rd_data),
        .ready_bits(ready_bits)
    );

    issue_queue u_iq (
        .clk(clk), .rstn(rstn), .ren(ren), .dispatch(dispatch), .ready_bits(ready_bits),
        .rd_data(rd_data), .complete(complete), .stall(iq_stall), .rd_tag(rd_tag),
        .issue(issue)
    );

    alu_unit alu0 (.clk(clk), .rstn(rstn), .issue(issue[0]), .result(complete[0]));
    alu_unit alu1 (.clk(clk), .rstn(rstn), .issue(issue[1]), .result(complete[1]));
    alu_unit alu2 (.clk(clk), .rstn(rstn), .issue(issue[2]), .result(complete[2]));

    reorder_buffer u_rob (
        .clk(clk), .rstn(rstn), .ren(ren), .old_pdst(old_pdst), .dispatch(dispatch),
        .complete(complete), .stall(rob_stall), .rob_tail(rob_tail), .retire(retire),
        .free_valid(free_valid), .free_tag(free_tag)
    );

endmodule

`default_nettype wire

//--- tb_ooo_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defines.svh"

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int HALF        = 20;
    localparam int WD_PER_INSN = 200;
    localparam int WD_MARGIN   = 500;

    logic             clk;
    logic             rstn;
    logic             insn_valid;
    logic [`XLEN-1:0] insn;
    logic             stall;
    retire_t          retire;

    retire_t          exp_q [$];
    logic [31:0]      arch_regs [32];
    logic [31:0]      rng_state;
    int               err_value;
    int               err_other;
    int               sent;
    int               cycles;

    ooo_core dut (
        .clk(clk), .rstn(rstn), .insn_valid(insn_valid), .insn(insn),
        .stall(stall), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF) clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // xorshift32.
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [31:0] random_insn();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          pick;
        r    = next_rand();
        rd   = {2'b00, r[2:0]};
        rs1  = {2'b00, r[5:3]};
        rs2  = {2'b00, r[8:6]};
        imm  = r[20:9];
        pick = int'(r[31:16]) % 19;
        case (pick)
            0:  return r_type(7'h00, 3'b000, rd, rs1, rs2);
            1:  return r_type(7'h20, 3'b000, rd, rs1, rs2);
            2:  return r_type(7'h00, 3'b001, rd, rs1, rs2);
            3:  return r_type(7'h00, 3'b010, rd, rs1, rs2);
            4:  return r_type(7'h00, 3'b011, rd, rs1, rs2);
            5:  return r_type(7'h00, 3'b100, rd, rs1, rs2);
            6:  return r_type(7'h00, 3'b101, rd, rs1, rs2);
            7:  return r_type(7'h20, 3'b101, rd, rs1, rs2);
            8:  return r_type(7'h00, 3'b110, rd, rs1, rs2);
            9:  return r_type(7'h00, 3'b111, rd, rs1, rs2);
            10: return i_type(imm, 3'b000, rd, rs1);
            11: return i_type(imm, 3'b010, rd, rs1);
            12: return i_type(imm, 3'b011, rd, rs1);
            13: return i_type(imm, 3'b100, rd, rs1);
            14: return i_type(imm, 3'b110, rd, rs1);
            15: return i_type(imm, 3'b111, rd, rs1);
            16: return i_type({7'h00, imm[4:0]}, 3'b001, rd, rs1);
            17: return i_type({7'h00, imm[4:0]}, 3'b101, rd, rs1);
            default: return i_type({7'h20, imm[4:0]}, 3'b101, rd, rs1);
        endcase
    endfunction

    // architectural result of one instruction from the rv32i rules.
    task automatic predict(input logic [31:0] word);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        ok;
        retire_t     exp;
        opc = word[6:0];
        f3  = word[14:12];
        f7  = word[31:25];
        rd  = word[11:7];
        a   = arch_regs[word[19:15]];
        b   = '0;
        ok  = 1'b0;
        if (opc == 7'b0110011) begin
            b  = arch_regs[word[24:20]];
            ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        end else if (opc == 7'b0010011) begin
            b  = {{20{word[31]}}, word[31:20]};
            ok = (f3 == 3'b001) ? (f7 == 7'h00) :
                 (f3 == 3'b101) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        end
        case (f3)
            3'b000:  res = (opc == 7'b0110011 && f7 == 7'h20) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = {31'b0, $signed(a) < $signed(b)};
            3'b011:  res = {31'b0, a < b};
            3'b100:  res = a ^ b;
            3'b101: begin
                if (f7 == 7'h20) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        exp.valid = 1'b1;
        if (ok && rd != 5'd0) begin
            arch_regs[rd] = res;
            exp.rd        = rd;
            exp.value     = res;
        end else begin
            exp.rd    = 5'd0;
            exp.value = '0;
        end
        exp_q.push_back(exp);
        sent++;
    endtask

    // stall is sampled mid low phase before the accepting edge.
    task automatic send_insn(input logic [31:0] word);
        @(negedge clk);
        insn_valid = 1'b1;
        insn       = word;
        #(HALF/2);
        while (stall) begin
            @(negedge clk);
            #(HALF/2);
        end
        predict(word);
    endtask

    task automatic go_idle();
        @(negedge clk);
        insn_valid = 1'b0;
        insn       = '0;
    endtask

    task automatic drain(input int limit);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d instructions did not retire within %0d cycles", exp_q.size(), limit);
            err_other++;
        end
    endtask

    task automatic check_retire(input retire_t exp, input retire_t got);
        if (got.rd !== exp.rd || got.value !== exp.value) begin
            $display("Error: retire rd/value expected %h/%h got %h/%h",
                     exp.rd, exp.value, got.rd, got.value);
            err_value++;
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, got);
            err_value++;
        end
    endtask

    task automatic reset_state_check();
        @(negedge clk);
        check_level("stall", 1'b0, stall);
        check_level("retire.valid", 1'b0, retire.valid);
        send_insn(i_type(12'h005, 3'b000, 5'd0, 5'd0));
        // lui is outside the supported set.
        send_insn({20'h12345, 5'd3, 7'b0110111});
        go_idle();
        drain(200);
    endtask

    task automatic run_all_ops();
        send_insn(i_type(12'hff3, 3'b000, 5'd1, 5'd0));
        send_insn(i_type(12'h005, 3'b000, 5'd2, 5'd0));
        send_insn(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        send_insn(r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
        send_insn(r_type(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
        send_insn(r_type(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
        send_insn(r_type(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
        send_insn(r_type(7'h00, 3'b001, 5'd8, 5'd1, 5'd2));
        send_insn(r_type(7'h00, 3'b101, 5'd9, 5'd1, 5'd2));
        send_insn(r_type(7'h20, 3'b101, 5'd10, 5'd1, 5'd2));
        send_insn(r_type(7'h00, 3'b010, 5'd11, 5'd1, 5'd2));
        send_insn(r_type(7'h00, 3'b011, 5'd12, 5'd1, 5'd2));
        send_insn(i_type(12'h064, 3'b000, 5'd13, 5'd1));
        send_insn(i_type(12'hfec, 3'b010, 5'd14, 5'd1));
        send_insn(i_type(12'h007, 3'b011, 5'd15, 5'd2));
        send_insn(i_type(12'h555, 3'b100, 5'd16, 5'd1));
        send_insn(i_type(12'h0f0, 3'b110, 5'd17, 5'd2));
        send_insn(i_type(12'h7f0, 3'b111, 5'd18, 5'd1));
        send_insn(i_type({7'h00, 5'd3}, 3'b001, 5'd19, 5'd1));
        send_insn(i_type({7'h00, 5'd4}, 3'b101, 5'd20, 5'd1));
        send_insn(i_type({7'h20, 5'd4}, 3'b101, 5'd21, 5'd1));
        go_idle();
        drain(400);
    endtask

    // every step reads the rd of the step before.
    task automatic dependence_chain();
        logic [4:0]  rd;
        logic [4:0]  prev;
        logic [31:0] word;
        send_insn(i_type(12'h001, 3'b000, 5'd5, 5'd0));
        prev = 5'd5;
        for (int i = 0; i < 24; i++) begin
            rd = 5'd6 + 5'(i % 3);
            case (i % 4)
                0:       word = i_type(12'(i + 1), 3'b000, rd, prev);
                1:       word = r_type(7'h00, 3'b000, rd, prev, prev);
                2:       word = i_type(12'h05a, 3'b100, rd, prev);
                default: word = i_type(12'h001, 3'b001, rd, prev);
            endcase
            send_insn(word);
            prev = rd;
        end
        go_idle();
        drain(600);
    endtask

    // four registers rewritten well past the free list size.
    task automatic register_recycle();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] word;
        for (int i = 0; i < 100; i++) begin
            rd  = 5'(1 + i % 4);
            rs1 = 5'(1 + (i + 1) % 4);
            rs2 = 5'(1 + (i + 3) % 4);
            case (i % 5)
                0:       word = i_type(12'(i * 7), 3'b000, rd, rs1);
                1:       word = r_type(7'h00, 3'b000, rd, rs1, rs2);
                2:       word = r_type(7'h20, 3'b000, rd, rs1, rs2);
                3:       word = r_type(7'h00, 3'b100, rd, rs1, rs2);
                default: word = r_type(7'h00, 3'b010, rd, rs1, rs2);
            endcase
            send_insn(word);
        end
        go_idle();
        drain(2000);
    endtask

    task automatic random_burst();
        for (int i = 0; i < 60; i++) begin
            send_insn(random_insn());
        end
        go_idle();
        drain(1500);
    endtask

    always @(negedge clk) begin
        if (rstn && retire.valid) begin
            if (exp_q.size() == 0) begin
                $display("a retirement arrived with no instruction outstanding");
                err_other++;
            end else begin
                check_retire(exp_q.pop_front(), retire);
            end
        end
    end

    // budget grows with every instruction accepted.
    initial begin
        cycles = 0;
        while (cycles <= WD_PER_INSN * sent + WD_MARGIN) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d instructions sent", cycles, sent);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rstn       = 1'b0;
        insn_valid = 1'b0;
        insn       = '0;
        err_value  = 0;
        err_other  = 0;
        sent       = 0;
        rng_state  = 32'd41811;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        reset_state_check();
        run_all_ops();
        dependence_chain();
        register_recycle();
        random_burst();
        $display("value errors: %0d, other errors: %0d", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
ooo_pkg.sv
insn_decoder.sv
rename_unit.sv
phys_regfile.sv
issue_queue.sv
alu_unit.sv
reorder_buffer.sv
ooo_core.sv
tb_ooo_core.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module tb_ooo_core -f sim.f -o tb_ooo_core > sim.log 2>&1 \
    && ./obj_dir/tb_ooo_core >> sim.log 2>&1
grep -q "NO ERRORS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
